/* common/bp_cce_cfg_pkg.sv */
package bp_cce_cfg_pkg;

  localparam int paddr_width_lp     = 32;
  localparam int data_width_lp      = 64;
  localparam int num_lce_lp         = 2;
  localparam int lce_id_width_lp    = $clog2(num_lce_lp);
  localparam int sync_cnt_width_lp  = $clog2(num_lce_lp + 1);
  localparam int mem_credits_lp     = 4;
  localparam int credit_width_lp    = $clog2(mem_credits_lp + 1);
  localparam int fifo_els_lp        = 2;
  localparam int fifo_ptr_width_lp  = $clog2(fifo_els_lp);
  localparam int fifo_cnt_width_lp  = $clog2(fifo_els_lp + 1);
  // 1, 2, 4 or 8 bytes
  localparam int size_width_lp      = 2;

endpackage

/* common/bp_cce_msg_pkg.sv */
package bp_cce_msg_pkg;
  import bp_cce_cfg_pkg::*;

  typedef enum logic [0:0] {
    e_lce_req_uc_rd = 1'b0,
    e_lce_req_uc_wr = 1'b1
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_lce_cmd_sync       = 2'd0,
    e_lce_cmd_uc_data    = 2'd1,
    e_lce_cmd_uc_st_done = 2'd2
  } lce_cmd_type_e;

  typedef enum logic [0:0] {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } mem_cmd_type_e;

  typedef struct packed {
    lce_req_type_e                msg_type;
    logic [lce_id_width_lp-1:0]   src_id;
    logic [paddr_width_lp-1:0]    addr;
    logic [size_width_lp-1:0]     size;
  } lce_req_header_s;

  // Sync acks only
  typedef struct packed {
    logic [lce_id_width_lp-1:0]   src_id;
  } lce_resp_header_s;

  typedef struct packed {
    lce_cmd_type_e                msg_type;
    logic [lce_id_width_lp-1:0]   dst_id;
    logic [paddr_width_lp-1:0]    addr;
    logic [size_width_lp-1:0]     size;
  } lce_cmd_header_s;

  // Shared by memory commands and responses
  typedef struct packed {
    mem_cmd_type_e                msg_type;
    logic [lce_id_width_lp-1:0]   lce_id;
    logic [paddr_width_lp-1:0]    addr;
    logic [size_width_lp-1:0]     size;
  } mem_header_s;

  typedef struct packed {
    mem_header_s                  header;
    logic [data_width_lp-1:0]     data;
  } mem_msg_s;

  typedef struct packed {
    lce_cmd_header_s              header;
    logic [data_width_lp-1:0]     data;
  } lce_cmd_msg_s;

endpackage

/* common/lce_cmd_if.sv */
`timescale 1ns/1ns

interface lce_cmd_if
  import bp_cce_msg_pkg::*;
  (input logic clk_i);

  lce_cmd_msg_s msg;
  logic         v;
  logic         ready_and;

  modport source (input clk_i, output msg, output v, input ready_and);
  modport sink (input clk_i, input msg, input v, output ready_and);

endinterface

/* src/bp_cce_msg_fifo.sv */
`timescale 1ns/1ns

module bp_cce_msg_fifo
  import bp_cce_cfg_pkg::*;
  #(parameter type payload_t = bp_cce_msg_pkg::mem_msg_s)
  (input                clk_i
   , input              reset_i
   , input payload_t    data_i
   , input              v_i
   , output logic       ready_and_o
   , output payload_t   data_o
   , output logic       v_o
   , input              ready_and_i
   );

  payload_t mem_r [fifo_els_lp];
  logic [fifo_ptr_width_lp-1:0] wptr_r, rptr_r;
  logic [fifo_cnt_width_lp-1:0] count_r;
  logic enq, deq;

  assign ready_and_o = (count_r != fifo_cnt_width_lp'(fifo_els_lp));
  assign v_o         = (count_r != '0);
  assign data_o      = mem_r[rptr_r];
  assign enq         = v_i & ready_and_o;
  assign deq         = v_o & ready_and_i;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= (wptr_r == fifo_ptr_width_lp'(fifo_els_lp - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (deq) begin
        rptr_r <= (rptr_r == fifo_ptr_width_lp'(fifo_els_lp - 1)) ? '0 : rptr_r + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (enq & ~deq) begin
        count_r <= count_r + 1'b1;
      end else if (deq & ~enq) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

/* src/bp_cce_sync_ctrl.sv */
`timescale 1ns/1ns

module bp_cce_sync_ctrl
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                       clk_i
   , input                     reset_i
   , input lce_resp_header_s   lce_resp_header_i
   , input                     lce_resp_v_i
   , output logic              lce_resp_ready_and_o
   , lce_cmd_if.source         cmd_o
   , output logic              sync_done_o
   );

  typedef enum logic [1:0] {e_send, e_wait, e_done} state_e;

  state_e state_r;
  logic [lce_id_width_lp-1:0] lce_idx_r;
  logic [sync_cnt_width_lp-1:0] ack_cnt_r;
  logic cmd_fire, ack_synced, ack_fire, last_lce, last_ack;

  // Acks absorbed whenever out of reset
  assign lce_resp_ready_and_o = ~reset_i;

  assign cmd_fire   = cmd_o.v & cmd_o.ready_and;
  // Ignore acks from an LCE that has not seen its sync yet
  assign ack_synced = (state_r != e_send) | (lce_resp_header_i.src_id < lce_idx_r);
  assign ack_fire   = lce_resp_v_i & lce_resp_ready_and_o & ack_synced & (state_r != e_done);
  assign last_lce   = (lce_idx_r == lce_id_width_lp'(num_lce_lp - 1));
  assign last_ack   = (ack_cnt_r == sync_cnt_width_lp'(num_lce_lp - 1));

  always_comb begin
    cmd_o.msg                 = '0;
    cmd_o.msg.header.msg_type = e_lce_cmd_sync;
    cmd_o.msg.header.dst_id   = lce_idx_r;
  end

  // First sync goes out in the cycle after reset
  assign cmd_o.v     = (state_r == e_send) & ~reset_i;
  assign sync_done_o = (state_r == e_done);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= e_send;
      lce_idx_r <= '0;
      ack_cnt_r <= '0;
    end else begin
      if (ack_fire) begin
        ack_cnt_r <= ack_cnt_r + 1'b1;
      end
      case (state_r)
        e_send: begin
          if (cmd_fire) begin
            if (last_lce) begin
              state_r <= e_wait;
            end else begin
              lce_idx_r <= lce_idx_r + 1'b1;
            end
          end
        end
        e_wait: begin
          if (ack_fire & last_ack) begin
            state_r <= e_done;
          end
        end
        default: begin
          state_r <= e_done;
        end
      endcase
    end
  end

endmodule

/* src/bp_cce_lce_cmd_arb.sv */
`timescale 1ns/1ns

module bp_cce_lce_cmd_arb
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                 clk_i
   , input                               reset_i
   , lce_cmd_if.sink                     src0_i
   , lce_cmd_if.sink                     src1_i
   , output lce_cmd_header_s             lce_cmd_header_o
   , output logic [data_width_lp-1:0]    lce_cmd_data_o
   , output logic                        lce_cmd_v_o
   , input                               lce_cmd_ready_and_i
   );

  logic last_grant1_r;
  logic locked_r, locked_grant1_r;
  logic pick1, grant0, grant1;
  lce_cmd_msg_s msg_sel;

  // Source 1 wins a tie only when source 0 went last
  assign pick1  = ~src0_i.v | ~last_grant1_r;
  // Stalled grant is held so the output stays stable
  assign grant1 = src1_i.v & (locked_r ? locked_grant1_r : pick1);
  assign grant0 = src0_i.v & ~grant1;

  assign msg_sel          = grant1 ? src1_i.msg : src0_i.msg;
  assign lce_cmd_header_o = msg_sel.header;
  assign lce_cmd_data_o   = msg_sel.data;
  assign lce_cmd_v_o      = grant0 | grant1;

  assign src0_i.ready_and = grant0 & lce_cmd_ready_and_i;
  assign src1_i.ready_and = grant1 & lce_cmd_ready_and_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_grant1_r   <= 1'b1;
      locked_r        <= 1'b0;
      locked_grant1_r <= 1'b0;
    end else if (lce_cmd_v_o & lce_cmd_ready_and_i) begin
      last_grant1_r <= grant1;
      locked_r      <= 1'b0;
    end else if (lce_cmd_v_o) begin
      locked_r        <= 1'b1;
      locked_grant1_r <= grant1;
    end
  end

endmodule

/* uc/bp_cce_mem_credits.sv */
`timescale 1ns/1ns

module bp_cce_mem_credits
  import bp_cce_cfg_pkg::*;
  (input           clk_i
   , input         reset_i
   , input         consume_i
   , input         return_i
   , output logic  credit_avail_o
   );

  logic [credit_width_lp-1:0] count_r;

  assign credit_avail_o = (count_r < credit_width_lp'(mem_credits_lp));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (consume_i & ~return_i) begin
      count_r <= count_r + 1'b1;
    end else if (return_i & ~consume_i) begin
      count_r <= count_r - 1'b1;
    end
  end

endmodule

/* uc/bp_cce_uc_req_pipe.sv */
`timescale 1ns/1ns

module bp_cce_uc_req_pipe
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                 clk_i
   , input                               reset_i
   , input                               sync_done_i
   , input                               credit_avail_i
   , output logic                        credit_consume_o
   , input lce_req_header_s              lce_req_header_i
   , input [data_width_lp-1:0]           lce_req_data_i
   , input                               lce_req_v_i
   , output logic                        lce_req_ready_and_o
   , output mem_header_s                 mem_cmd_header_o
   , output logic [data_width_lp-1:0]    mem_cmd_data_o
   , output logic                        mem_cmd_v_o
   , input                               mem_cmd_ready_and_i
   );

  mem_msg_s req_msg, cmd_msg;
  logic fifo_ready, req_allowed;

  // No requests before sync, and none past the credit limit
  assign req_allowed         = sync_done_i & credit_avail_i;
  assign lce_req_ready_and_o = req_allowed & fifo_ready;
  assign credit_consume_o    = lce_req_v_i & lce_req_ready_and_o;

  always_comb begin
    req_msg.header.msg_type = (lce_req_header_i.msg_type == e_lce_req_uc_wr)
                              ? e_mem_uc_wr : e_mem_uc_rd;
    req_msg.header.lce_id   = lce_req_header_i.src_id;
    req_msg.header.addr     = lce_req_header_i.addr;
    req_msg.header.size     = lce_req_header_i.size;
    req_msg.data            = lce_req_data_i;
  end

  bp_cce_msg_fifo #(.payload_t(mem_msg_s)) cmd_fifo
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.data_i(req_msg)
    ,.v_i(lce_req_v_i & req_allowed)
    ,.ready_and_o(fifo_ready)
    ,.data_o(cmd_msg)
    ,.v_o(mem_cmd_v_o)
    ,.ready_and_i(mem_cmd_ready_and_i)
    );

  assign mem_cmd_header_o = cmd_msg.header;
  assign mem_cmd_data_o   = cmd_msg.data;

endmodule

/* uc/bp_cce_mem_resp_pipe.sv */
`timescale 1ns/1ns

module bp_cce_mem_resp_pipe
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                 clk_i
   , input                               reset_i
   , input mem_header_s                  mem_resp_header_i
   , input [data_width_lp-1:0]           mem_resp_data_i
   , input                               mem_resp_v_i
   , output logic                        mem_resp_ready_and_o
   , output logic                        credit_return_o
   , lce_cmd_if.source                   cmd_o
   );

  lce_cmd_msg_s resp_msg;
  logic is_write;

  assign is_write        = (mem_resp_header_i.msg_type == e_mem_uc_wr);
  assign credit_return_o = mem_resp_v_i & mem_resp_ready_and_o;

  // Route back to the requesting LCE
  always_comb begin
    resp_msg.header.msg_type = is_write ? e_lce_cmd_uc_st_done : e_lce_cmd_uc_data;
    resp_msg.header.dst_id   = mem_resp_header_i.lce_id;
    resp_msg.header.addr     = mem_resp_header_i.addr;
    resp_msg.header.size     = mem_resp_header_i.size;
    // Store done carries no data
    resp_msg.data            = is_write ? '0 : mem_resp_data_i;
  end

  bp_cce_msg_fifo #(.payload_t(lce_cmd_msg_s)) cmd_fifo
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.data_i(resp_msg)
    ,.v_i(mem_resp_v_i)
    ,.ready_and_o(mem_resp_ready_and_o)
    ,.data_o(cmd_o.msg)
    ,.v_o(cmd_o.v)
    ,.ready_and_i(cmd_o.ready_and)
    );

endmodule

/* src/bp_cce_uc.sv */
`timescale 1ns/1ns

module bp_cce_uc
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  (input                                 clk_i
   , input                               reset_i

   , input lce_req_header_s              lce_req_header_i
   , input [data_width_lp-1:0]           lce_req_data_i
   , input                               lce_req_v_i
   , output logic                        lce_req_ready_and_o

   , input lce_resp_header_s             lce_resp_header_i
   , input                               lce_resp_v_i
   , output logic                        lce_resp_ready_and_o

   , output lce_cmd_header_s             lce_cmd_header_o
   , output logic [data_width_lp-1:0]    lce_cmd_data_o
   , output logic                        lce_cmd_v_o
   , input                               lce_cmd_ready_and_i

   , output mem_header_s                 mem_cmd_header_o
   , output logic [data_width_lp-1:0]    mem_cmd_data_o
   , output logic                        mem_cmd_v_o
   , input                               mem_cmd_ready_and_i

   , input mem_header_s                  mem_resp_header_i
   , input [data_width_lp-1:0]           mem_resp_data_i
   , input                               mem_resp_v_i
   , output logic                        mem_resp_ready_and_o
   );

  logic sync_done, credit_avail, credit_consume, credit_return;

  lce_cmd_if sync_cmd_if (.clk_i(clk_i));
  lce_cmd_if resp_cmd_if (.clk_i(clk_i));

  bp_cce_sync_ctrl sync_ctrl
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.lce_resp_header_i(lce_resp_header_i)
    ,.lce_resp_v_i(lce_resp_v_i)
    ,.lce_resp_ready_and_o(lce_resp_ready_and_o)
    ,.cmd_o(sync_cmd_if.source)
    ,.sync_done_o(sync_done)
    );

  bp_cce_mem_credits mem_credits
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.consume_i(credit_consume)
    ,.return_i(credit_return)
    ,.credit_avail_o(credit_avail)
    );

  bp_cce_uc_req_pipe req_pipe
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.sync_done_i(sync_done)
    ,.credit_avail_i(credit_avail)
    ,.credit_consume_o(credit_consume)
    ,.lce_req_header_i(lce_req_header_i)
    ,.lce_req_data_i(lce_req_data_i)
    ,.lce_req_v_i(lce_req_v_i)
    ,.lce_req_ready_and_o(lce_req_ready_and_o)
    ,.mem_cmd_header_o(mem_cmd_header_o)
    ,.mem_cmd_data_o(mem_cmd_data_o)
    ,.mem_cmd_v_o(mem_cmd_v_o)
    ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
    );

  bp_cce_mem_resp_pipe mem_resp_pipe
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.mem_resp_header_i(mem_resp_header_i)
    ,.mem_resp_data_i(mem_resp_data_i)
    ,.mem_resp_v_i(mem_resp_v_i)
    ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
    ,.credit_return_o(credit_return)
    ,.cmd_o(resp_cmd_if.source)
    );

  // Sync commands on port 0, memory responses on port 1
  bp_cce_lce_cmd_arb lce_cmd_arb
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.src0_i(sync_cmd_if.sink)
    ,.src1_i(resp_cmd_if.sink)
    ,.lce_cmd_header_o(lce_cmd_header_o)
    ,.lce_cmd_data_o(lce_cmd_data_o)
    ,.lce_cmd_v_o(lce_cmd_v_o)
    ,.lce_cmd_ready_and_i(lce_cmd_ready_and_i)
    );

endmodule

/* test/tb_bp_cce_uc.sv */
`timescale 1ns/1ns

module tb_bp_cce_uc
  import bp_cce_cfg_pkg::*;
  import bp_cce_msg_pkg::*;
  ();

  localparam int num_rows_lp = 8;

  typedef struct packed {
    lce_req_type_e               op;
    logic [lce_id_width_lp-1:0]  lce;
    logic [paddr_width_lp-1:0]   addr;
    logic [size_width_lp-1:0]    size;
    logic [data_width_lp-1:0]    data;
    lce_cmd_type_e               exp_type;
    logic [data_width_lp-1:0]    exp_data;
  } row_s;

  logic clk, reset, withhold;
  lce_req_header_s lce_req_header;
  logic [data_width_lp-1:0] lce_req_data, mem_cmd_data_o, lce_cmd_data_o, mem_resp_data;
  logic lce_req_v, lce_req_ready_and_o, lce_resp_v, lce_resp_ready_and_o;
  lce_resp_header_s lce_resp_header;
  lce_cmd_header_s lce_cmd_header_o, lce_hdr_q;
  logic lce_cmd_v_o, lce_cmd_ready, mem_cmd_v_o, mem_cmd_ready, mem_resp_v, mem_resp_ready_and_o;
  mem_header_s mem_cmd_header_o, mem_resp_header, mem_hdr_q, exp_mem_hdr;
  logic [data_width_lp-1:0] lce_data_q, mem_data_q, rd_data;
  logic lce_stall, mem_stall;

  row_s rows [num_rows_lp];
  bit row_done [num_rows_lp];
  int row_err [num_rows_lp];
  int errors, accepted, mem_cmd_cnt, mem_resp_cnt, sync_cnt, acks_given, done_cnt;
  int cycle, hit;
  logic [31:0] rng;

  // Memory model state
  logic [data_width_lp-1:0] mem [logic [paddr_width_lp-1:0]];
  mem_header_s pend_hdr [$];
  logic [data_width_lp-1:0] pend_data [$];
  int pend_due [$];

  bp_cce_uc DUT
   (.clk_i(clk), .reset_i(reset)
    ,.lce_req_header_i(lce_req_header), .lce_req_data_i(lce_req_data)
    ,.lce_req_v_i(lce_req_v), .lce_req_ready_and_o(lce_req_ready_and_o)
    ,.lce_resp_header_i(lce_resp_header), .lce_resp_v_i(lce_resp_v)
    ,.lce_resp_ready_and_o(lce_resp_ready_and_o)
    ,.lce_cmd_header_o(lce_cmd_header_o), .lce_cmd_data_o(lce_cmd_data_o)
    ,.lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_ready_and_i(lce_cmd_ready)
    ,.mem_cmd_header_o(mem_cmd_header_o), .mem_cmd_data_o(mem_cmd_data_o)
    ,.mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_ready_and_i(mem_cmd_ready)
    ,.mem_resp_header_i(mem_resp_header), .mem_resp_data_i(mem_resp_data)
    ,.mem_resp_v_i(mem_resp_v), .mem_resp_ready_and_o(mem_resp_ready_and_o)
    );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // op, LCE, address, size, data, expected command, expected data
  task automatic load_table();
    rows[0] = '{e_lce_req_uc_wr, 1'b0, 32'h0000_1000, 2'd3, 64'h0123_4567_89ab_cdef,
                e_lce_cmd_uc_st_done, 64'h0};
    rows[1] = '{e_lce_req_uc_wr, 1'b1, 32'h0000_2040, 2'd2, 64'hfeed_face_cafe_beef,
                e_lce_cmd_uc_st_done, 64'h0};
    rows[2] = '{e_lce_req_uc_rd, 1'b0, 32'h0000_1000, 2'd3, 64'h0,
                e_lce_cmd_uc_data, 64'h0123_4567_89ab_cdef};
    rows[3] = '{e_lce_req_uc_rd, 1'b1, 32'h0000_3300, 2'd3, 64'h0,
                e_lce_cmd_uc_data, 64'h0000_3300_0000_3300};
    rows[4] = '{e_lce_req_uc_wr, 1'b0, 32'h0000_4008, 2'd1, 64'h5555_aaaa_0f0f_f0f0,
                e_lce_cmd_uc_st_done, 64'h0};
    rows[5] = '{e_lce_req_uc_rd, 1'b1, 32'h0000_2040, 2'd2, 64'h0,
                e_lce_cmd_uc_data, 64'hfeed_face_cafe_beef};
    rows[6] = '{e_lce_req_uc_rd, 1'b0, 32'h0000_4008, 2'd1, 64'h0,
                e_lce_cmd_uc_data, 64'h5555_aaaa_0f0f_f0f0};
    rows[7] = '{e_lce_req_uc_rd, 1'b1, 32'h0000_5a5c, 2'd0, 64'h0,
                e_lce_cmd_uc_data, 64'h0000_5a5c_0000_5a5c};
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] got, input int row);
    $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
    errors++;
    if (row >= 0 && row < num_rows_lp) begin
      row_err[row]++;
    end
  endtask

  task automatic send_rows();
    for (int i = 0; i < num_rows_lp; i++) begin
      lce_req_header <= '{rows[i].op, rows[i].lce, rows[i].addr, rows[i].size};
      lce_req_data   <= rows[i].data;
      lce_req_v      <= 1'b1;
      @(posedge clk);
      while (!lce_req_ready_and_o) begin
        @(posedge clk);
      end
    end
    lce_req_v <= 1'b0;
  endtask

  task automatic match_cmd();
    int idx;
    idx = -1;
    for (int i = 0; i < num_rows_lp; i++) begin
      if (rows[i].addr == lce_cmd_header_o.addr && rows[i].lce == lce_cmd_header_o.dst_id
          && rows[i].exp_type == lce_cmd_header_o.msg_type) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("LCE command to LCE %0d for address %h matches no request",
               lce_cmd_header_o.dst_id, lce_cmd_header_o.addr);
      errors++;
    end else if (row_done[idx]) begin
      $display("Second LCE command for row %0d, address %h", idx, lce_cmd_header_o.addr);
      errors++;
    end else begin
      if (lce_cmd_header_o.size !== rows[idx].size) begin
        report_mismatch("lce_cmd_header_o.size", rows[idx].size, lce_cmd_header_o.size, idx);
      end
      if (lce_cmd_data_o !== rows[idx].exp_data) begin
        report_mismatch("lce_cmd_data_o", rows[idx].exp_data, lce_cmd_data_o, idx);
      end
      row_done[idx] = 1'b1;
      done_cnt++;
      $display("test row %0d (%s, LCE %0d, addr %h): %s", idx,
               rows[idx].op == e_lce_req_uc_wr ? "store" : "load", rows[idx].lce,
               rows[idx].addr, row_err[idx] == 0 ? "passed" : "failed");
    end
  endtask

  // LCE model answers every sync
  always @(posedge clk) begin
    if (reset) begin
      lce_resp_v <= 1'b0;
    end else begin
      if (lce_resp_v && lce_resp_ready_and_o) begin
        acks_given <= acks_given + 1;
        lce_resp_v <= 1'b0;
      end
      if (lce_cmd_v_o && lce_cmd_ready && lce_cmd_header_o.msg_type == e_lce_cmd_sync) begin
        lce_resp_header.src_id <= lce_cmd_header_o.dst_id;
        lce_resp_v             <= 1'b1;
      end
    end
  end

  // Memory model and random ready patterns
  always @(posedge clk) begin
    if (reset) begin
      lce_cmd_ready <= 1'b0;
      mem_cmd_ready <= 1'b0;
      mem_resp_v    <= 1'b0;
    end else begin
      cycle++;
      rng = next_random(rng);
      lce_cmd_ready <= rng[3];
      mem_cmd_ready <= rng[11];
      if (mem_cmd_v_o && mem_cmd_ready) begin
        if (mem_cmd_header_o.msg_type == e_mem_uc_wr) begin
          mem[mem_cmd_header_o.addr] = mem_cmd_data_o;
        end
        // Unwritten words read back as their address
        rd_data = mem.exists(mem_cmd_header_o.addr) ? mem[mem_cmd_header_o.addr]
                  : {mem_cmd_header_o.addr, mem_cmd_header_o.addr};
        pend_hdr.push_back(mem_cmd_header_o);
        pend_data.push_back(rd_data);
        pend_due.push_back(cycle + int'(rng[22:20]));
      end
      if (!mem_resp_v || mem_resp_ready_and_o) begin
        mem_resp_v <= 1'b0;
        hit = -1;
        for (int i = 0; i < pend_due.size(); i++) begin
          if (hit < 0 && pend_due[i] <= cycle) begin
            hit = i;
          end
        end
        if (!withhold && hit >= 0) begin
          mem_resp_header <= pend_hdr[hit];
          mem_resp_data   <= pend_data[hit];
          mem_resp_v      <= 1'b1;
          pend_hdr.delete(hit);
          pend_data.delete(hit);
          pend_due.delete(hit);
        end
      end
    end
  end

  // Monitor of all DUT channels
  always @(posedge clk) begin
    if (!reset) begin
      if (lce_req_v && lce_req_ready_and_o) begin
        accepted <= accepted + 1;
      end
      if (lce_req_ready_and_o && acks_given < num_lce_lp) begin
        $display("Request channel ready at %0t before all sync acks", $time);
        errors++;
      end
      if (lce_resp_ready_and_o !== 1'b1) begin
        report_mismatch("lce_resp_ready_and_o", 1'b1, lce_resp_ready_and_o, -1);
      end
      if (mem_resp_v && mem_resp_ready_and_o) begin
        mem_resp_cnt <= mem_resp_cnt + 1;
      end
      if (accepted - mem_resp_cnt > mem_credits_lp
          || mem_cmd_cnt - mem_resp_cnt > mem_credits_lp) begin
        $display("More than %0d memory transactions in flight at %0t", mem_credits_lp, $time);
        errors++;
      end
      if (mem_cmd_v_o && mem_cmd_ready) begin
        if (mem_cmd_cnt >= accepted || mem_cmd_cnt >= num_rows_lp) begin
          $display("Memory command at %0t with no request behind it", $time);
          errors++;
        end else begin
          // A store done row needs a memory write
          exp_mem_hdr.msg_type = (rows[mem_cmd_cnt].exp_type == e_lce_cmd_uc_st_done)
                                 ? e_mem_uc_wr : e_mem_uc_rd;
          exp_mem_hdr.lce_id   = rows[mem_cmd_cnt].lce;
          exp_mem_hdr.addr     = rows[mem_cmd_cnt].addr;
          exp_mem_hdr.size     = rows[mem_cmd_cnt].size;
          if (mem_cmd_header_o !== exp_mem_hdr) begin
            report_mismatch("mem_cmd_header_o", exp_mem_hdr, mem_cmd_header_o, mem_cmd_cnt);
          end
          if (rows[mem_cmd_cnt].op == e_lce_req_uc_wr
              && mem_cmd_data_o !== rows[mem_cmd_cnt].data) begin
            report_mismatch("mem_cmd_data_o", rows[mem_cmd_cnt].data, mem_cmd_data_o,
                            mem_cmd_cnt);
          end
        end
        mem_cmd_cnt <= mem_cmd_cnt + 1;
      end
      if (lce_cmd_v_o && lce_cmd_ready) begin
        if (lce_cmd_header_o.msg_type == e_lce_cmd_sync) begin
          if (sync_cnt >= num_lce_lp) begin
            $display("Extra sync command at %0t", $time);
            errors++;
          end else if (lce_cmd_header_o.dst_id != sync_cnt) begin
            report_mismatch("lce_cmd_header_o.dst_id", sync_cnt, lce_cmd_header_o.dst_id, -1);
          end
          sync_cnt <= sync_cnt + 1;
        end else begin
          match_cmd();
        end
      end
      // Stalled outputs must hold
      if (lce_stall && (!lce_cmd_v_o
          || {lce_cmd_header_o, lce_cmd_data_o} !== {lce_hdr_q, lce_data_q})) begin
        report_mismatch("lce_cmd_header_o/lce_cmd_data_o", {lce_hdr_q, lce_data_q},
                        {lce_cmd_header_o, lce_cmd_data_o}, -1);
      end
      if (mem_stall && (!mem_cmd_v_o
          || {mem_cmd_header_o, mem_cmd_data_o} !== {mem_hdr_q, mem_data_q})) begin
        report_mismatch("mem_cmd_header_o/mem_cmd_data_o", {mem_hdr_q, mem_data_q},
                        {mem_cmd_header_o, mem_cmd_data_o}, -1);
      end
    end
    lce_stall  <= !reset && lce_cmd_v_o && !lce_cmd_ready;
    mem_stall  <= !reset && mem_cmd_v_o && !mem_cmd_ready;
    lce_hdr_q  <= lce_cmd_header_o;
    lce_data_q <= lce_cmd_data_o;
    mem_hdr_q  <= mem_cmd_header_o;
    mem_data_q <= mem_cmd_data_o;
  end

  initial begin
    #((200 * num_rows_lp + 100) * 20);
    $display("Timeout: only %0d of %0d rows finished", done_cnt, num_rows_lp);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int base;
    clk = 1'b0;
    reset = 1'b1;
    withhold = 1'b1;
    rng = 32'h9191_fc27;
    lce_req_header = '0;
    lce_req_data = '0;
    lce_req_v = 1'b0;
    lce_resp_header = '0;
    lce_resp_v = 1'b0;
    lce_cmd_ready = 1'b0;
    mem_cmd_ready = 1'b0;
    mem_resp_header = '0;
    mem_resp_data = '0;
    mem_resp_v = 1'b0;
    load_table();
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    wait (acks_given == num_lce_lp);
    @(posedge clk);
    if (sync_cnt != num_lce_lp) begin
      $display("Saw %0d sync commands instead of %0d", sync_cnt, num_lce_lp);
      errors++;
    end
    $display("test sync: %s", errors == 0 ? "passed" : "failed");

    base = errors;
    fork
      send_rows();
      begin
        // Responses held back until the credit limit is reached
        wait (accepted == mem_credits_lp && mem_cmd_cnt == mem_credits_lp);
        repeat (20) @(posedge clk);
        if (accepted != mem_credits_lp || mem_cmd_cnt != mem_credits_lp) begin
          $display("Credit limit broken: %0d accepted, %0d memory commands", accepted, mem_cmd_cnt);
          errors++;
        end
        $display("test credits: %s", errors == base ? "passed" : "failed");
        withhold <= 1'b0;
      end
    join
    wait (done_cnt == num_rows_lp);
    repeat (10) @(posedge clk);
    if (mem_cmd_cnt != num_rows_lp) begin
      $display("Saw %0d memory commands for %0d rows", mem_cmd_cnt, num_rows_lp);
      errors++;
    end

    $display("%0d tests, %0d rows done, %0d errors", num_rows_lp + 2, done_cnt, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* project.f */
common/bp_cce_cfg_pkg.sv
common/bp_cce_msg_pkg.sv
common/lce_cmd_if.sv
src/bp_cce_msg_fifo.sv
src/bp_cce_sync_ctrl.sv
src/bp_cce_lce_cmd_arb.sv
uc/bp_cce_mem_credits.sv
uc/bp_cce_uc_req_pipe.sv
uc/bp_cce_mem_resp_pipe.sv
src/bp_cce_uc.sv
test/tb_bp_cce_uc.sv
